/* logic/radio_pkg.sv */
/*
 * Constants shared by the bus-side radio packet block.
 * Header word layout is flag[63:60], seq[59:48], len[47:32], sid[31:0].
 * Route is taken from the two low SID bits of the header word.
 */
`default_nettype none

package radio_pkg;

   // Word and header field positions
   localparam int WORD_W = 64;
   localparam int SID_LO = 0;
   localparam int SID_HI = 31;
   localparam int SEQ_LO = 48;
   localparam int SEQ_HI = 59;
   localparam int LEN_LO = 32;
   localparam int LEN_HI = 47;
   localparam int ROUTE_W = 2;

   // Command word layout
   localparam int ADDR_LO = 32;
   localparam int ADDR_HI = 39;
   localparam int SET_ADDR_W = 8;
   localparam int SET_DATA_W = 32;

   // Route codes from SID[1:0]
   localparam logic [ROUTE_W-1:0] ROUTE_TX_DATA = 2'd0;
   localparam logic [ROUTE_W-1:0] ROUTE_CTRL    = 2'd1;
   localparam logic [ROUTE_W-1:0] ROUTE_RX_FC   = 2'd2;
   localparam logic [ROUTE_W-1:0] ROUTE_RX_CMD  = 2'd3;

   // Setting addresses
   localparam logic [SET_ADDR_W-1:0] SR_DACSYNC   = 8'd5;
   localparam logic [SET_ADDR_W-1:0] SR_TEST      = 8'd7;
   localparam logic [SET_ADDR_W-1:0] SR_MISC_OUTS = 8'd24;
   localparam logic [SET_ADDR_W-1:0] SR_READBACK  = 8'd32;
   localparam logic [SET_ADDR_W-1:0] SR_TX_ACK    = 8'd68;

   // Generated header contents
   localparam logic [15:0] RESP_LEN_BYTES = 16'd16;
   localparam logic [3:0]  ACK_FLAG = 4'd1;
   localparam int RB_SEL_W = 2;

endpackage

`default_nettype wire

/* logic/sid_demux.sv */
/*
 * Packet steering by SID[1:0] of the header word. The route is held
 * from header to last word. Routes 2 and 3 are sunk and always ready.
 */
`timescale 1ns/1ps
`default_nettype none

module sid_demux (
   input  wire                          i_bus_clk,
   input  wire                          i_bus_rst,
   input  wire  [radio_pkg::WORD_W-1:0] i_tdata,
   input  wire                          i_tlast,
   input  wire                          i_tvalid,
   output logic                         o_tready,
   output logic [radio_pkg::WORD_W-1:0] o_tx_tdata,
   output logic                         o_tx_tlast,
   output logic                         o_tx_tvalid,
   input  wire                          i_tx_tready,
   output logic [radio_pkg::WORD_W-1:0] o_ctrl_tdata,
   output logic                         o_ctrl_tlast,
   output logic                         o_ctrl_tvalid,
   input  wire                          i_ctrl_tready
);
   import radio_pkg::*;

   logic               first_q;
   logic [ROUTE_W-1:0] route_q;
   logic [ROUTE_W-1:0] route;
   wire                in_xfer = i_tvalid && o_tready;

   // Header word decides directly, later words use the held route
   assign route = first_q ? i_tdata[SID_LO +: ROUTE_W] : route_q;

   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         first_q <= 1'b1;
         route_q <= ROUTE_TX_DATA;
      end else if (in_xfer) begin
         first_q <= i_tlast;
         if (first_q)
            route_q <= route;
      end
   end

   always_comb begin
      case (route)
         ROUTE_TX_DATA:            o_tready = i_tx_tready;
         ROUTE_CTRL:               o_tready = i_ctrl_tready;
         ROUTE_RX_FC, ROUTE_RX_CMD: o_tready = 1'b1;
      endcase
   end

   assign o_tx_tdata    = i_tdata;
   assign o_tx_tlast    = i_tlast;
   assign o_tx_tvalid   = i_tvalid && (route == ROUTE_TX_DATA);
   assign o_ctrl_tdata  = i_tdata;
   assign o_ctrl_tlast  = i_tlast;
   assign o_ctrl_tvalid = i_tvalid && (route == ROUTE_CTRL);

endmodule

`default_nettype wire

/* logic/ctrl_proc.sv */
/*
 * Control packet processor. Only the first command word is executed,
 * extra words are dropped. Each packet gets a two-word response of
 * header plus readback. No new control word is taken until the
 * response is out.
 */
`timescale 1ns/1ps
`default_nettype none

module ctrl_proc (
   input  wire                              i_bus_clk,
   input  wire                              i_bus_rst,
   input  wire  [radio_pkg::WORD_W-1:0]     i_tdata,
   input  wire                              i_tlast,
   input  wire                              i_tvalid,
   output logic                             o_tready,
   output logic                             o_set_stb,
   output logic [radio_pkg::SET_ADDR_W-1:0] o_set_addr,
   output logic [radio_pkg::SET_DATA_W-1:0] o_set_data,
   input  wire  [radio_pkg::WORD_W-1:0]     i_rb_data,
   output logic [radio_pkg::WORD_W-1:0]     o_resp_tdata,
   output logic                             o_resp_tlast,
   output logic                             o_resp_tvalid,
   input  wire                              i_resp_tready
);
   import radio_pkg::*;

   localparam logic [2:0] ST_HDR       = 3'd0;
   localparam logic [2:0] ST_CMD       = 3'd1;
   localparam logic [2:0] ST_DRAIN     = 3'd2;
   localparam logic [2:0] ST_SET       = 3'd3;
   localparam logic [2:0] ST_RESP_HDR  = 3'd4;
   localparam logic [2:0] ST_RESP_DATA = 3'd5;

   logic [2:0]             state;
   logic [SEQ_HI-SEQ_LO:0] seq_q;
   logic [SID_HI-SID_LO:0] sid_q;
   wire                    in_xfer = i_tvalid && o_tready;

   //////////////////////////////////////////////////////////////////////
   // Packet FSM

   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         state     <= ST_HDR;
         o_set_stb <= 1'b0;
      end else begin
         o_set_stb <= (state == ST_CMD) && in_xfer;
         case (state)
            ST_HDR: begin
               if (in_xfer)
                  state <= i_tlast ? ST_SET : ST_CMD;
            end
            ST_CMD: begin
               if (in_xfer)
                  state <= i_tlast ? ST_SET : ST_DRAIN;
            end
            ST_DRAIN: begin
               if (in_xfer && i_tlast)
                  state <= ST_RESP_HDR;
            end
            // One cycle for the register write to land before readback
            ST_SET:       state <= ST_RESP_HDR;
            ST_RESP_HDR: begin
               if (i_resp_tready)
                  state <= ST_RESP_DATA;
            end
            ST_RESP_DATA: begin
               if (i_resp_tready)
                  state <= ST_HDR;
            end
            default:      state <= ST_HDR;
         endcase
      end
   end

   always_ff @(posedge i_bus_clk) begin
      if ((state == ST_HDR) && in_xfer) begin
         seq_q <= i_tdata[SEQ_HI:SEQ_LO];
         sid_q <= i_tdata[SID_HI:SID_LO];
      end
      if ((state == ST_CMD) && in_xfer) begin
         o_set_addr <= i_tdata[ADDR_HI:ADDR_LO];
         o_set_data <= i_tdata[SET_DATA_W-1:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Response

   assign o_tready      = (state == ST_HDR) || (state == ST_CMD) || (state == ST_DRAIN);
   assign o_resp_tvalid = (state == ST_RESP_HDR) || (state == ST_RESP_DATA);
   assign o_resp_tlast  = (state == ST_RESP_DATA);
   // Flag 0 marks a readback response and the SID halves are swapped
   assign o_resp_tdata  = o_resp_tlast ? i_rb_data :
                          {4'd0, seq_q, RESP_LEN_BYTES, sid_q[15:0], sid_q[31:16]};

endmodule

`default_nettype wire

/* logic/settings_regs.sv */
/*
 * Setting registers and readback mux. Registers change the cycle after
 * the strobe. A write of any value to SR_DACSYNC gives a one-cycle pulse.
 */
`timescale 1ns/1ps
`default_nettype none

module settings_regs #(
   parameter int RADIO_NUM = 0
) (
   input  wire                              i_bus_clk,
   input  wire                              i_bus_rst,
   input  wire                              i_set_stb,
   input  wire  [radio_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  wire  [radio_pkg::SET_DATA_W-1:0] i_set_data,
   input  wire  [radio_pkg::SET_DATA_W-1:0] i_misc_ins,
   output logic [radio_pkg::SET_DATA_W-1:0] o_misc_outs,
   output logic                             o_sync_dacs,
   output logic [radio_pkg::WORD_W-1:0]     o_rb_data
);
   import radio_pkg::*;

   logic [SET_DATA_W-1:0] test_q;
   logic [RB_SEL_W-1:0]   rb_sel;

   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         test_q      <= '0;
         o_misc_outs <= '0;
         rb_sel      <= '0;
         o_sync_dacs <= 1'b0;
      end else begin
         o_sync_dacs <= i_set_stb && (i_set_addr == SR_DACSYNC);
         if (i_set_stb) begin
            case (i_set_addr)
               SR_TEST:      test_q      <= i_set_data;
               SR_MISC_OUTS: o_misc_outs <= i_set_data;
               SR_READBACK:  rb_sel      <= i_set_data[RB_SEL_W-1:0];
               default:      ;
            endcase
         end
      end
   end

   // Readback mux
   always_comb begin
      case (rb_sel)
         2'd0:    o_rb_data = {o_misc_outs, test_q};
         2'd1:    o_rb_data = {i_misc_ins, test_q};
         2'd2:    o_rb_data = {{SET_DATA_W{1'b0}}, SET_DATA_W'(RADIO_NUM)};
         default: o_rb_data = '0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/tx_pre_fifo.sv */
/*
 * Synchronous FIFO for TX words and their last flag. A written word is
 * visible at the output the next cycle. Holds 2**FIFO_DEPTH_LOG2 words.
 */
`timescale 1ns/1ps
`default_nettype none

module tx_pre_fifo #(
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  wire                          i_bus_clk,
   input  wire                          i_bus_rst,
   input  wire  [radio_pkg::WORD_W-1:0] i_tdata,
   input  wire                          i_tlast,
   input  wire                          i_tvalid,
   output logic                         o_tready,
   output logic [radio_pkg::WORD_W-1:0] o_tdata,
   output logic                         o_tlast,
   output logic                         o_tvalid,
   input  wire                          i_tready
);
   import radio_pkg::*;

   localparam int DEPTH = 2 ** FIFO_DEPTH_LOG2;

   logic [WORD_W:0]          mem [DEPTH];
   logic [FIFO_DEPTH_LOG2:0] wr_ptr, rd_ptr;
   wire                      wr_en = i_tvalid && o_tready;
   wire                      rd_en = o_tvalid && i_tready;

   // Extra pointer bit tells full from empty
   assign o_tvalid = (wr_ptr != rd_ptr);
   assign o_tready = (wr_ptr ^ rd_ptr) != {1'b1, {FIFO_DEPTH_LOG2{1'b0}}};
   assign {o_tlast, o_tdata} = mem[rd_ptr[FIFO_DEPTH_LOG2-1:0]];

   always_ff @(posedge i_bus_clk) begin
      if (wr_en)
         mem[wr_ptr[FIFO_DEPTH_LOG2-1:0]] <= {i_tlast, i_tdata};
   end

   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/tx_responder.sv */
/*
 * TX flow-control ACK source. Sends one ACK per N packets consumed at
 * the FIFO output, N from SR_TX_ACK with 0 turning ACKs off. Up to
 * eight ACKs can wait on a stalled output, further ones are dropped.
 */
`timescale 1ns/1ps
`default_nettype none

module tx_responder (
   input  wire                              i_bus_clk,
   input  wire                              i_bus_rst,
   input  wire                              i_set_stb,
   input  wire  [radio_pkg::SET_ADDR_W-1:0] i_set_addr,
   input  wire  [radio_pkg::SET_DATA_W-1:0] i_set_data,
   input  wire  [radio_pkg::WORD_W-1:0]     i_tx_tdata,
   input  wire                              i_tx_tlast,
   input  wire                              i_tx_tvalid,
   input  wire                              i_tx_tready,
   output logic [radio_pkg::WORD_W-1:0]     o_ack_tdata,
   output logic                             o_ack_tlast,
   output logic                             o_ack_tvalid,
   input  wire                              i_ack_tready
);
   import radio_pkg::*;

   localparam int Q_LOG2 = 3;
   localparam int SEQ_W  = SEQ_HI - SEQ_LO + 1;
   localparam int SID_W  = SID_HI - SID_LO + 1;

   logic [SET_DATA_W-1:0]             pkts_per_ack, pkt_cnt, total;
   logic                              first_q, ack_word;
   logic [SEQ_W-1:0]                  seq_q, cur_seq, h_seq;
   logic [SID_W-1:0]                  sid_q, cur_sid, h_sid;
   logic [SET_DATA_W-1:0]             h_total;
   logic [SEQ_W+SID_W+SET_DATA_W-1:0] ackq [2**Q_LOG2];
   logic [Q_LOG2:0]                   q_wr, q_rd;

   wire xfer   = i_tx_tvalid && i_tx_tready;
   wire done   = xfer && i_tx_tlast;
   wire due    = done && (pkts_per_ack != '0) && (pkt_cnt + 1'b1 >= pkts_per_ack);
   wire q_full = (q_wr ^ q_rd) == {1'b1, {Q_LOG2{1'b0}}};
   wire pop    = o_ack_tvalid && i_ack_tready && ack_word;

   // Single-word packets finish on their own header
   assign cur_seq = first_q ? i_tx_tdata[SEQ_HI:SEQ_LO] : seq_q;
   assign cur_sid = first_q ? i_tx_tdata[SID_HI:SID_LO] : sid_q;

   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         pkts_per_ack <= '0;
         pkt_cnt      <= '0;
         total        <= '0;
         first_q      <= 1'b1;
         ack_word     <= 1'b0;
         q_wr         <= '0;
         q_rd         <= '0;
      end else begin
         if (i_set_stb && (i_set_addr == SR_TX_ACK))
            pkts_per_ack <= i_set_data;
         if (xfer)
            first_q <= i_tx_tlast;
         if (done) begin
            total   <= total + 1'b1;
            pkt_cnt <= due ? '0 : pkt_cnt + 1'b1;
         end
         if (due && !q_full)
            q_wr <= q_wr + 1'b1;
         if (o_ack_tvalid && i_ack_tready)
            ack_word <= !ack_word;
         if (pop)
            q_rd <= q_rd + 1'b1;
      end
   end

   always_ff @(posedge i_bus_clk) begin
      if (xfer && first_q) begin
         seq_q <= i_tx_tdata[SEQ_HI:SEQ_LO];
         sid_q <= i_tx_tdata[SID_HI:SID_LO];
      end
      if (due && !q_full)
         ackq[q_wr[Q_LOG2-1:0]] <= {cur_seq, cur_sid, total + 1'b1};
   end

   assign {h_seq, h_sid, h_total} = ackq[q_rd[Q_LOG2-1:0]];

   assign o_ack_tvalid = (q_wr != q_rd);
   assign o_ack_tlast  = ack_word;
   assign o_ack_tdata  = ack_word ? {{(WORD_W-SET_DATA_W){1'b0}}, h_total} :
                         {ACK_FLAG, h_seq, RESP_LEN_BYTES, h_sid[15:0], h_sid[31:16]};

endmodule

`default_nettype wire

/* logic/resp_arbiter.sv */
/*
 * Two-input packet merge. The grant is fixed from the first offered
 * word to the last transfer, and alternates when both inputs wait.
 */
`timescale 1ns/1ps
`default_nettype none

module resp_arbiter (
   input  wire                          i_bus_clk,
   input  wire                          i_bus_rst,
   input  wire  [radio_pkg::WORD_W-1:0] i_a_tdata,
   input  wire                          i_a_tlast,
   input  wire                          i_a_tvalid,
   output logic                         o_a_tready,
   input  wire  [radio_pkg::WORD_W-1:0] i_b_tdata,
   input  wire                          i_b_tlast,
   input  wire                          i_b_tvalid,
   output logic                         o_b_tready,
   output logic [radio_pkg::WORD_W-1:0] o_tdata,
   output logic                         o_tlast,
   output logic                         o_tvalid,
   input  wire                          i_tready
);
   logic gnt_q;
   logic locked;
   logic sel;

   // gnt_q also remembers the last source served
   always_comb begin
      if (locked)
         sel = gnt_q;
      else if (i_a_tvalid && i_b_tvalid)
         sel = !gnt_q;
      else
         sel = i_b_tvalid;
   end

   always_ff @(posedge i_bus_clk) begin
      if (i_bus_rst) begin
         gnt_q  <= 1'b0;
         locked <= 1'b0;
      end else if (o_tvalid) begin
         gnt_q  <= sel;
         locked <= !(i_tready && o_tlast);
      end
   end

   assign o_tdata    = sel ? i_b_tdata  : i_a_tdata;
   assign o_tlast    = sel ? i_b_tlast  : i_a_tlast;
   assign o_tvalid   = sel ? i_b_tvalid : i_a_tvalid;
   assign o_a_tready = i_tready && !sel;
   assign o_b_tready = i_tready && sel;

endmodule

`default_nettype wire

/* logic/radio_core.sv */
/*
 * Bus-clock packet side of the radio block. One input stream is split
 * by SID[1:0]. Route 0 goes to the TX port, route 1 to the settings
 * processor, routes 2 and 3 are discarded. Responses and TX ACKs share
 * the output port. Everything runs on bus_clk.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_core #(
   parameter int RADIO_NUM       = 0,
   parameter int FIFO_DEPTH_LOG2 = 4
) (
   input  wire                              i_bus_clk,
   input  wire                              i_bus_rst,
   input  wire  [radio_pkg::WORD_W-1:0]     i_in_tdata,
   input  wire                              i_in_tlast,
   input  wire                              i_in_tvalid,
   output logic                             o_in_tready,
   output logic [radio_pkg::WORD_W-1:0]     o_out_tdata,
   output logic                             o_out_tlast,
   output logic                             o_out_tvalid,
   input  wire                              i_out_tready,
   output logic [radio_pkg::WORD_W-1:0]     o_tx_tdata,
   output logic                             o_tx_tlast,
   output logic                             o_tx_tvalid,
   input  wire                              i_tx_tready,
   input  wire  [radio_pkg::SET_DATA_W-1:0] i_misc_ins,
   output logic [radio_pkg::SET_DATA_W-1:0] o_misc_outs,
   output logic                             o_sync_dacs
);
   import radio_pkg::*;

   logic [WORD_W-1:0]     dmx_tx_tdata, ctrl_tdata, resp_tdata, ack_tdata;
   logic                  dmx_tx_tlast, dmx_tx_tvalid, dmx_tx_tready;
   logic                  ctrl_tlast, ctrl_tvalid, ctrl_tready;
   logic                  resp_tlast, resp_tvalid, resp_tready;
   logic                  ack_tlast, ack_tvalid, ack_tready;
   logic                  set_stb;
   logic [SET_ADDR_W-1:0] set_addr;
   logic [SET_DATA_W-1:0] set_data;
   logic [WORD_W-1:0]     rb_data;

   //////////////////////////////////////////////////////////////////////
   // Input split and settings

   sid_demux u_demux (
      .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
      .i_tdata(i_in_tdata), .i_tlast(i_in_tlast),
      .i_tvalid(i_in_tvalid), .o_tready(o_in_tready),
      .o_tx_tdata(dmx_tx_tdata), .o_tx_tlast(dmx_tx_tlast),
      .o_tx_tvalid(dmx_tx_tvalid), .i_tx_tready(dmx_tx_tready),
      .o_ctrl_tdata(ctrl_tdata), .o_ctrl_tlast(ctrl_tlast),
      .o_ctrl_tvalid(ctrl_tvalid), .i_ctrl_tready(ctrl_tready));

   ctrl_proc u_ctrl (
      .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
      .i_tdata(ctrl_tdata), .i_tlast(ctrl_tlast),
      .i_tvalid(ctrl_tvalid), .o_tready(ctrl_tready),
      .o_set_stb(set_stb), .o_set_addr(set_addr), .o_set_data(set_data),
      .i_rb_data(rb_data),
      .o_resp_tdata(resp_tdata), .o_resp_tlast(resp_tlast),
      .o_resp_tvalid(resp_tvalid), .i_resp_tready(resp_tready));

   settings_regs #(.RADIO_NUM(RADIO_NUM)) u_regs (
      .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_misc_ins(i_misc_ins), .o_misc_outs(o_misc_outs),
      .o_sync_dacs(o_sync_dacs), .o_rb_data(rb_data));

   //////////////////////////////////////////////////////////////////////
   // Transmit path and output merge

   tx_pre_fifo #(.FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)) u_tx_fifo (
      .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
      .i_tdata(dmx_tx_tdata), .i_tlast(dmx_tx_tlast),
      .i_tvalid(dmx_tx_tvalid), .o_tready(dmx_tx_tready),
      .o_tdata(o_tx_tdata), .o_tlast(o_tx_tlast),
      .o_tvalid(o_tx_tvalid), .i_tready(i_tx_tready));

   // Counts packets as they leave the FIFO
   tx_responder u_tx_resp (
      .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
      .i_set_stb(set_stb), .i_set_addr(set_addr), .i_set_data(set_data),
      .i_tx_tdata(o_tx_tdata), .i_tx_tlast(o_tx_tlast),
      .i_tx_tvalid(o_tx_tvalid), .i_tx_tready(i_tx_tready),
      .o_ack_tdata(ack_tdata), .o_ack_tlast(ack_tlast),
      .o_ack_tvalid(ack_tvalid), .i_ack_tready(ack_tready));

   resp_arbiter u_arb (
      .i_bus_clk(i_bus_clk), .i_bus_rst(i_bus_rst),
      .i_a_tdata(resp_tdata), .i_a_tlast(resp_tlast),
      .i_a_tvalid(resp_tvalid), .o_a_tready(resp_tready),
      .i_b_tdata(ack_tdata), .i_b_tlast(ack_tlast),
      .i_b_tvalid(ack_tvalid), .o_b_tready(ack_tready),
      .o_tdata(o_out_tdata), .o_tlast(o_out_tlast),
      .o_tvalid(o_out_tvalid), .i_tready(i_out_tready));

endmodule

`default_nettype wire

/* verification/radio_core_tb.sv */
/*
 * Testbench for radio_core. Mixed random traffic on all four routes with
 * valid gaps and random back-pressure on both outputs, checked against a
 * queue model. SR_TX_ACK is only rewritten while the TX path is idle, so
 * the ACK prediction does not depend on timing.
 */
`timescale 1ns/1ps
`default_nettype none

module radio_core_tb;
   import radio_pkg::*;

   localparam int SEED           = 32'h313a;
   localparam int RADIO_NUM      = 3;
   localparam int PHASES         = 4;
   localparam int PKTS_PER_PHASE = 40;
   localparam int NUM_PKTS       = PHASES * (PKTS_PER_PHASE + 1);

   logic              bus_clk, bus_rst;
   logic [WORD_W-1:0] in_tdata, out_tdata, tx_tdata;
   logic              in_tlast, in_tvalid, in_tready;
   logic              out_tlast, out_tvalid, out_tready;
   logic              tx_tlast, tx_tvalid, tx_tready;
   logic [31:0]       misc_ins, misc_outs;
   logic              sync_dacs;

   // Reference model state
   int                seed, bp_seed;
   logic [WORD_W:0]   tx_exp [$];
   logic [WORD_W-1:0] resp_exp [$];
   logic [WORD_W-1:0] ack_exp [$];
   logic [31:0]       misc_exp [$];
   logic [31:0]       m_test, m_misc, m_total, m_cnt, m_n;
   logic [1:0]        m_rb_sel;
   int                dac_writes, dac_pulses;
   int                tx_errs, out_errs, reg_errs;
   logic              out_second, out_is_ack;
   logic [WORD_W:0]   exp_tx;

   radio_core #(.RADIO_NUM(RADIO_NUM), .FIFO_DEPTH_LOG2(4)) uut (
      .i_bus_clk(bus_clk), .i_bus_rst(bus_rst),
      .i_in_tdata(in_tdata), .i_in_tlast(in_tlast),
      .i_in_tvalid(in_tvalid), .o_in_tready(in_tready),
      .o_out_tdata(out_tdata), .o_out_tlast(out_tlast),
      .o_out_tvalid(out_tvalid), .i_out_tready(out_tready),
      .o_tx_tdata(tx_tdata), .o_tx_tlast(tx_tlast),
      .o_tx_tvalid(tx_tvalid), .i_tx_tready(tx_tready),
      .i_misc_ins(misc_ins), .o_misc_outs(misc_outs), .o_sync_dacs(sync_dacs));

   initial begin
      bus_clk = 1'b0;
      forever #4 bus_clk = ~bus_clk;
   end

   // Generated header with the flag, same seq, 16 bytes and swapped SID halves
   function automatic logic [63:0] reply_header(input logic [3:0] flag, input logic [63:0] hdr);
      return {flag, hdr[59:48], 16'd16, hdr[15:0], hdr[31:16]};
   endfunction

   function automatic logic [63:0] expected_readback();
      case (m_rb_sel)
         2'd0:    return {m_misc, m_test};
         2'd1:    return {misc_ins, m_test};
         2'd2:    return {32'd0, 32'(RADIO_NUM)};
         default: return 64'd0;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Stimulus

   task automatic send_word(input logic [63:0] data, input logic last);
      logic acc;
      in_tdata  = data;
      in_tlast  = last;
      in_tvalid = 1'b1;
      acc = 1'b0;
      while (!acc) begin
         @(negedge bus_clk);
         acc = in_tready;
         @(posedge bus_clk);
         #1;
      end
      in_tvalid = 1'b0;
      if (($random(seed) & 3) == 0) begin
         repeat (($random(seed) & 3) + 1) begin
            @(posedge bus_clk);
            #1;
         end
      end
   endtask

   task automatic send_tx_packet();
      int len;
      logic [63:0] hdr, w;
      len = 2 + ($random(seed) & 7);
      hdr = {$random(seed), $random(seed)};
      hdr[1:0] = ROUTE_TX_DATA;
      // One ACK once N packets have been consumed since the last one
      m_total = m_total + 1;
      if (m_n != 0 && m_cnt + 1 >= m_n) begin
         ack_exp.push_back(reply_header(ACK_FLAG, hdr));
         ack_exp.push_back({32'd0, m_total});
         m_cnt = 0;
      end else begin
         m_cnt = m_cnt + 1;
      end
      for (int i = 0; i < len; i++) begin
         w = (i == 0) ? hdr : {$random(seed), $random(seed)};
         tx_exp.push_back({i == len - 1, w});
         send_word(w, i == len - 1);
      end
   endtask

   task automatic send_ctrl_packet(input logic [7:0] addr, input logic [31:0] data,
                                   input int extra);
      logic [63:0] hdr, cmd;
      hdr = {$random(seed), $random(seed)};
      hdr[1:0] = ROUTE_CTRL;
      cmd = {$random(seed), data};
      cmd[ADDR_HI:ADDR_LO] = addr;
      case (addr)
         SR_TEST:      m_test = data;
         SR_MISC_OUTS: m_misc = data;
         SR_READBACK:  m_rb_sel = data[1:0];
         SR_DACSYNC:   dac_writes++;
         SR_TX_ACK:    m_n = data;
         default:      ;
      endcase
      resp_exp.push_back(reply_header(4'h0, hdr));
      resp_exp.push_back(expected_readback());
      misc_exp.push_back(m_misc);
      send_word(hdr, 1'b0);
      send_word(cmd, extra == 0);
      // Words after the command are ignored by the DUT
      for (int i = 1; i <= extra; i++)
         send_word({$random(seed), $random(seed)}, i == extra);
   endtask

   task automatic send_sink_packet();
      int len;
      logic [63:0] hdr;
      len = 1 + ($random(seed) & 3);
      hdr = {$random(seed), $random(seed)};
      hdr[1] = 1'b1;
      for (int i = 0; i < len; i++)
         send_word((i == 0) ? hdr : {$random(seed), $random(seed)}, i == len - 1);
   endtask

   task automatic send_random_packet();
      int pick;
      logic [7:0] addr;
      pick = $random(seed) & 15;
      case ($random(seed) & 7)
         0, 1:    addr = SR_TEST;
         2, 3:    addr = SR_MISC_OUTS;
         4:       addr = SR_READBACK;
         5:       addr = SR_DACSYNC;
         default: addr = 8'd9;
      endcase
      if (pick < 8)
         send_tx_packet();
      else if (pick < 13)
         send_ctrl_packet(addr, $random(seed), $random(seed) & 3);
      else
         send_sink_packet();
   endtask

   task automatic wait_idle();
      do
         @(posedge bus_clk);
      while (tx_exp.size() != 0 || resp_exp.size() != 0 || ack_exp.size() != 0);
      #1;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Output checks at the falling clock edge

   task automatic check_out_word(input logic second);
      string name;
      logic [63:0] exp;
      logic [31:0] m;
      logic have;
      name = out_is_ack ? (second ? "ack_count" : "ack_header") :
                          (second ? "resp_readback" : "resp_header");
      have = out_is_ack ? (ack_exp.size() != 0) : (resp_exp.size() != 0);
      assert (have) else begin
         out_errs++;
         $display("Output word %h arrived while no such packet was expected", out_tdata);
      end
      if (have) begin
         exp = out_is_ack ? ack_exp.pop_front() : resp_exp.pop_front();
         assert (out_tdata == exp) else begin
            out_errs++;
            $display("ERR %s expected %h actual %h", name, exp, out_tdata);
         end
         assert (out_tlast == second) else begin
            out_errs++;
            $display("ERR %s_last expected %0d actual %0d", name, second, out_tlast);
         end
         if (second && !out_is_ack) begin
            m = misc_exp.pop_front();
            assert (misc_outs == m) else begin
               reg_errs++;
               $display("ERR misc_outs expected %h actual %h", m, misc_outs);
            end
         end
      end
   endtask

   always @(negedge bus_clk) begin
      if (!bus_rst) begin
         if (sync_dacs)
            dac_pulses++;
         if (tx_tvalid && tx_tready) begin
            assert (tx_exp.size() != 0) else begin
               tx_errs++;
               $display("TX word %h arrived while none was expected", tx_tdata);
            end
            if (tx_exp.size() != 0) begin
               exp_tx = tx_exp.pop_front();
               assert ({tx_tlast, tx_tdata} == exp_tx) else begin
                  tx_errs++;
                  $display("ERR tx_data expected %h actual %h", exp_tx, {tx_tlast, tx_tdata});
               end
            end
         end
         if (out_tvalid && out_tready) begin
            if (!out_second)
               out_is_ack = (out_tdata[63:60] == ACK_FLAG);
            check_out_word(out_second);
            out_second = !out_second;
         end
      end
   end

   // Random back-pressure on both outputs
   initial begin
      forever begin
         @(posedge bus_clk);
         #1;
         out_tready = ($random(bp_seed) & 3) != 0;
         tx_tready  = ($random(bp_seed) & 3) != 0;
      end
   end

   initial begin
      repeat (NUM_PKTS * 200) @(posedge bus_clk);
      $display("Timeout: traffic did not drain within %0d cycles", NUM_PKTS * 200);
      $display("Finished with errors");
      $finish;
   end

   initial begin
      seed = SEED;
      bp_seed = SEED ^ 32'h0000_ffff;
      in_tdata = '0;
      in_tlast = 1'b0;
      in_tvalid = 1'b0;
      out_tready = 1'b0;
      tx_tready = 1'b0;
      misc_ins = $random(seed);
      {m_test, m_misc, m_total, m_cnt, m_n, m_rb_sel} = '0;
      {dac_writes, dac_pulses, tx_errs, out_errs, reg_errs} = '0;
      out_second = 1'b0;
      out_is_ack = 1'b0;
      bus_rst = 1'b1;
      repeat (16) @(posedge bus_clk);
      #1 bus_rst = 1'b0;
      assert (!out_tvalid && !tx_tvalid && !sync_dacs) else begin
         reg_errs++;
         $display("Output valid or DAC sync was high right after reset");
      end
      for (int phase = 0; phase < PHASES; phase++) begin
         wait_idle();
         // Packets per ACK runs 2, 0, 3, 1 over the phases
         send_ctrl_packet(SR_TX_ACK, (phase * 3 + 2) % 5, 0);
         wait_idle();
         repeat (PKTS_PER_PHASE) send_random_packet();
      end
      wait_idle();
      repeat (100) @(posedge bus_clk);
      assert (dac_pulses == dac_writes) else begin
         reg_errs++;
         $display("ERR dac_pulses expected %0d actual %0d", dac_writes, dac_pulses);
      end
      $display("Error counts: tx %0d, output %0d, registers %0d", tx_errs, out_errs, reg_errs);
      if (tx_errs + out_errs + reg_errs == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
logic/radio_pkg.sv
logic/sid_demux.sv
logic/ctrl_proc.sv
logic/settings_regs.sv
logic/tx_pre_fifo.sv
logic/tx_responder.sv
logic/resp_arbiter.sv
logic/radio_core.sv
verification/radio_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the radio_core testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module radio_core_tb -o radio_sim \
   && ./obj_dir/radio_sim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log \
   && { echo "Simulation FAILED"; exit 1; } \
   || { echo "Simulation PASSED"; exit 0; }
